/* hw/fc_pkg.sv */
`default_nettype none

package fc_pkg;

    localparam int PE_NUM        = 8;   // also the tile size
    localparam int MAX_IN_NODES  = 32;
    localparam int MAX_OUT_NODES = 16;
    localparam int DATA_W        = 8;
    localparam int ACC_W         = 24;
    localparam int IBUF_AW       = 7;
    localparam int WBUF_AW       = 8;

    localparam int IN_CNT_W  = $clog2(MAX_IN_NODES + 1);
    localparam int OUT_CNT_W = $clog2(MAX_OUT_NODES + 1);
    localparam int OUT_IDX_W = $clog2(MAX_OUT_NODES);
    localparam int STEP_W    = $clog2(PE_NUM + MAX_OUT_NODES + 1);

    typedef logic signed [DATA_W-1:0] data_t;
    typedef data_t [PE_NUM-1:0]       wword_t;   // lane i feeds PE i
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [IBUF_AW-1:0]       ibuf_addr_t;
    typedef logic [WBUF_AW-1:0]       wbuf_addr_t;
    typedef logic [IN_CNT_W-1:0]      in_cnt_t;
    typedef logic [OUT_CNT_W-1:0]     out_cnt_t;
    typedef logic [STEP_W-1:0]        step_t;

    // layer slot base addresses
    localparam ibuf_addr_t IBUF_BASE0 = ibuf_addr_t'(0);
    localparam ibuf_addr_t IBUF_BASE1 = ibuf_addr_t'(32);
    localparam ibuf_addr_t IBUF_BASE2 = ibuf_addr_t'(64);
    localparam wbuf_addr_t WBUF_BASE0 = wbuf_addr_t'(0);
    localparam wbuf_addr_t WBUF_BASE1 = wbuf_addr_t'(64);
    localparam wbuf_addr_t WBUF_BASE2 = wbuf_addr_t'(128);

    typedef enum logic [1:0] {
        IDLE,
        IF_LOAD,
        FC_OP
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/fc_sram_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_sram_buffer #(
    parameter type word_t = logic [7:0],
    parameter int  AW     = 7
) (
    input  wire          clk,
    input  wire          rst_n,

    input  wire          wr_en_i,
    input  wire [AW-1:0] wr_addr_i,
    input  wire word_t   wr_data_i,

    input  wire          rd_en_i,
    input  wire [AW-1:0] rd_addr_i,
    output word_t        rd_data_o
);

    word_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data holds between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // host writes only while idle, the controller reads only while busy
    a_no_rw_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en_i && rd_en_i) |-> (wr_addr_i != rd_addr_i)
    ) else $error("read and write to the same buffer address");

endmodule

`default_nettype wire

/* hw/fc_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_controller (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      start_i,
    input  wire  [1:0]               layer_sel_i,
    input  wire  fc_pkg::in_cnt_t    in_nodes_i,   // 1..32
    input  wire  fc_pkg::out_cnt_t   out_nodes_i,  // 1..16
    output logic                     busy_o,

    output logic                     ifmap_rden_o,
    output fc_pkg::ibuf_addr_t       ifmap_rdptr_o,

    output logic                     wbuf_rden_o,
    output fc_pkg::wbuf_addr_t       wbuf_rdptr_o,
    output logic                     wzero_o,

    output logic                     pe_load_o,
    output logic                     pe_clear_o,

    output logic                     acc_valid_o,
    output logic                     acc_last_o,
    output logic                     acc_final_o
);

    fc_pkg::ctrl_state_e state;
    fc_pkg::step_t       cnt;
    fc_pkg::in_cnt_t     remain;     // inputs left, current tile included
    fc_pkg::out_cnt_t    out_n;
    fc_pkg::ibuf_addr_t  itile;      // first ifmap address of the tile
    fc_pkg::wbuf_addr_t  wtile;      // first weight word of the tile

    fc_pkg::in_cnt_t     tile_len;
    fc_pkg::step_t       op_end;
    logic                last_tile;
    logic                weight_rd;
    logic                out_window;

    logic                pe_load_q;
    logic                wzero_q;
    logic                acc_valid_q;
    logic                acc_last_q;
    logic                acc_final_q;

    always_comb begin
        if (remain > fc_pkg::in_cnt_t'(fc_pkg::PE_NUM)) begin
            tile_len  = fc_pkg::in_cnt_t'(fc_pkg::PE_NUM);
            last_tile = 1'b0;
        end else begin
            tile_len  = remain;
            last_tile = 1'b1;
        end
        op_end = fc_pkg::step_t'(fc_pkg::PE_NUM) + fc_pkg::step_t'(out_n);
    end

    assign weight_rd  = (state == fc_pkg::FC_OP) && (cnt < op_end);
    // chain output for word j is on psum PE_NUM+1 cycles after its read
    assign out_window = weight_rd && (cnt >= fc_pkg::step_t'(fc_pkg::PE_NUM));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= fc_pkg::IDLE;
            cnt    <= '0;
            remain <= '0;
            out_n  <= '0;
            itile  <= '0;
            wtile  <= '0;
        end else begin
            case (state)
                fc_pkg::IDLE: begin
                    if (start_i) begin
                        state  <= fc_pkg::IF_LOAD;
                        cnt    <= '0;
                        remain <= in_nodes_i;
                        out_n  <= out_nodes_i;
                        case (layer_sel_i)
                            2'd1: begin
                                itile <= fc_pkg::IBUF_BASE1;
                                wtile <= fc_pkg::WBUF_BASE1;
                            end
                            2'd2: begin
                                itile <= fc_pkg::IBUF_BASE2;
                                wtile <= fc_pkg::WBUF_BASE2;
                            end
                            default: begin  // 3 falls back to slot 0
                                itile <= fc_pkg::IBUF_BASE0;
                                wtile <= fc_pkg::WBUF_BASE0;
                            end
                        endcase
                    end
                end
                fc_pkg::IF_LOAD: begin
                    if (cnt == fc_pkg::step_t'(tile_len - 1'b1)) begin
                        state <= fc_pkg::FC_OP;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                fc_pkg::FC_OP: begin
                    if (acc_last_q) begin
                        cnt <= '0;
                        if (last_tile) begin
                            state <= fc_pkg::IDLE;
                        end else begin
                            state  <= fc_pkg::IF_LOAD;
                            remain <= remain - fc_pkg::in_cnt_t'(fc_pkg::PE_NUM);
                            itile  <= itile + fc_pkg::ibuf_addr_t'(fc_pkg::PE_NUM);
                            wtile  <= wtile + fc_pkg::wbuf_addr_t'(fc_pkg::MAX_OUT_NODES);
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= fc_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pe_load_q   <= 1'b0;
            wzero_q     <= 1'b0;
            acc_valid_q <= 1'b0;
            acc_last_q  <= 1'b0;
            acc_final_q <= 1'b0;
        end else begin
            pe_load_q   <= (state == fc_pkg::IF_LOAD);   // ifmap data arrives next cycle
            wzero_q     <= weight_rd && (cnt >= fc_pkg::step_t'(out_n));
            acc_valid_q <= out_window;
            acc_last_q  <= weight_rd && (cnt == op_end - 1'b1);
            acc_final_q <= out_window && last_tile;
        end
    end

    assign busy_o        = (state != fc_pkg::IDLE);
    assign ifmap_rden_o  = (state == fc_pkg::IF_LOAD);
    // read the tile backwards so input 0 ends up in PE 0
    assign ifmap_rdptr_o = itile + fc_pkg::ibuf_addr_t'(tile_len - 1'b1 - cnt);
    assign pe_clear_o    = (state == fc_pkg::IF_LOAD) && (cnt == '0);
    assign wbuf_rden_o   = weight_rd;
    assign wbuf_rdptr_o  = wtile + fc_pkg::wbuf_addr_t'(cnt);
    assign wzero_o       = wzero_q;
    assign pe_load_o     = pe_load_q;
    assign acc_valid_o   = acc_valid_q;
    assign acc_last_o    = acc_last_q;
    assign acc_final_o   = acc_final_q;

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_last_o |-> acc_valid_o
    ) else $error("acc_last without acc_valid");

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {fc_pkg::IDLE, fc_pkg::IF_LOAD, fc_pkg::FC_OP}
    ) else $error("controller state out of range");

endmodule

`default_nettype wire

/* hw/fc_pe_array.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_pe_array (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   load_i,
    input  wire                   clear_i,
    input  wire  fc_pkg::data_t   ifmap_i,

    input  wire  fc_pkg::wword_t  weight_i,
    input  wire                   wzero_i,

    output fc_pkg::acc_t          psum_o
);

    fc_pkg::data_t  in_reg [fc_pkg::PE_NUM];
    fc_pkg::acc_t   psum   [fc_pkg::PE_NUM];
    fc_pkg::wword_t w_in;

    assign w_in = wzero_i ? '0 : weight_i;   // drain without new terms

    // input chain, shifted upward from PE 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_reg <= '{default: '0};
        end else if (clear_i) begin
            in_reg <= '{default: '0};
        end else if (load_i) begin
            in_reg[0] <= ifmap_i;
            for (int i = 1; i < fc_pkg::PE_NUM; i++) begin
                in_reg[i] <= in_reg[i-1];
            end
        end
    end

    for (genvar i = 0; i < fc_pkg::PE_NUM; i++) begin : g_stage
        fc_pkg::data_t                   w_lane;
        logic signed [2*fc_pkg::DATA_W-1:0] prod;

        if (i == 0) begin : g_nodly
            assign w_lane = w_in[0];
        end else begin : g_dly
            fc_pkg::data_t dly [i];   // lane i waits i cycles

            always_ff @(posedge clk) begin
                dly[0] <= w_in[i];
                for (int d = 1; d < i; d++) begin
                    dly[d] <= dly[d-1];
                end
            end

            assign w_lane = dly[i-1];
        end

        assign prod = in_reg[i] * w_lane;

        if (i == 0) begin : g_first
            always_ff @(posedge clk) begin
                psum[0] <= prod;
            end
        end else begin : g_mac
            always_ff @(posedge clk) begin
                psum[i] <= psum[i-1] + prod;
            end
        end
    end

    assign psum_o = psum[fc_pkg::PE_NUM-1];

endmodule

`default_nettype wire

/* hw/fc_accumulator.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_accumulator (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire                 start_i,
    input  wire  fc_pkg::acc_t  psum_i,
    input  wire                 valid_i,
    input  wire                 last_i,
    input  wire                 final_i,

    output logic                result_valid_o,
    output fc_pkg::acc_t        result_data_o,
    output logic                result_last_o
);

    fc_pkg::acc_t     sums [fc_pkg::MAX_OUT_NODES];
    fc_pkg::out_cnt_t idx;     // one bit of headroom
    fc_pkg::acc_t     total;

    assign total = sums[idx[fc_pkg::OUT_IDX_W-1:0]] + psum_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (start_i || (valid_i && last_i)) begin
            idx <= '0;
        end else if (valid_i) begin
            idx <= idx + 1'b1;
        end
    end

    // partial sums of earlier tiles
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int j = 0; j < fc_pkg::MAX_OUT_NODES; j++) begin
                sums[j] <= '0;
            end
        end else if (valid_i && !final_i) begin
            sums[idx[fc_pkg::OUT_IDX_W-1:0]] <= total;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
            result_last_o  <= 1'b0;
        end else begin
            result_valid_o <= valid_i && final_i;
            result_last_o  <= valid_i && final_i && last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && final_i) begin
            result_data_o <= total[fc_pkg::ACC_W-1] ? '0 : total;   // relu
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_i |-> (idx <= fc_pkg::out_cnt_t'(fc_pkg::MAX_OUT_NODES - 1))
    ) else $error("output index beyond MAX_OUT_NODES");

endmodule

`default_nettype wire

/* hw/fc_engine_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_engine_top (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       wr_valid_i,
    output logic                      wr_ready_o,
    input  wire                       wr_sel_i,      // 0 ifmap, 1 weight
    input  wire  fc_pkg::wbuf_addr_t  wr_addr_i,     // ifmap uses the low bits
    input  wire  fc_pkg::data_t       wr_ifmap_i,
    input  wire  fc_pkg::wword_t      wr_weight_i,

    input  wire                       start_i,
    input  wire  [1:0]                layer_sel_i,
    input  wire  fc_pkg::in_cnt_t     in_nodes_i,
    input  wire  fc_pkg::out_cnt_t    out_nodes_i,
    output logic                      busy_o,

    output logic                      result_valid_o,
    output fc_pkg::acc_t              result_data_o,
    output logic                      result_last_o
);

    logic               ifmap_we;
    logic               wbuf_we;
    logic               start_go;
    logic               ifmap_rden;
    fc_pkg::ibuf_addr_t ifmap_rdptr;
    fc_pkg::data_t      ifmap_data;
    logic               wbuf_rden;
    fc_pkg::wbuf_addr_t wbuf_rdptr;
    fc_pkg::wword_t     wbuf_data;
    logic               wzero;
    logic               pe_load;
    logic               pe_clear;
    fc_pkg::acc_t       psum;
    logic               acc_valid;
    logic               acc_last;
    logic               acc_final;

    assign wr_ready_o = !busy_o;
    assign ifmap_we   = wr_valid_i && wr_ready_o && !wr_sel_i;
    assign wbuf_we    = wr_valid_i && wr_ready_o && wr_sel_i;
    assign start_go   = start_i && !busy_o;

    fc_sram_buffer #(
        .word_t (fc_pkg::data_t),
        .AW     (fc_pkg::IBUF_AW)
    ) u_ifmap_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (ifmap_we),
        .wr_addr_i (wr_addr_i[fc_pkg::IBUF_AW-1:0]),
        .wr_data_i (wr_ifmap_i),
        .rd_en_i   (ifmap_rden),
        .rd_addr_i (ifmap_rdptr),
        .rd_data_o (ifmap_data)
    );

    fc_sram_buffer #(
        .word_t (fc_pkg::wword_t),
        .AW     (fc_pkg::WBUF_AW)
    ) u_weight_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wbuf_we),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_weight_i),
        .rd_en_i   (wbuf_rden),
        .rd_addr_i (wbuf_rdptr),
        .rd_data_o (wbuf_data)
    );

    fc_controller u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_go),
        .layer_sel_i   (layer_sel_i),
        .in_nodes_i    (in_nodes_i),
        .out_nodes_i   (out_nodes_i),
        .busy_o        (busy_o),
        .ifmap_rden_o  (ifmap_rden),
        .ifmap_rdptr_o (ifmap_rdptr),
        .wbuf_rden_o   (wbuf_rden),
        .wbuf_rdptr_o  (wbuf_rdptr),
        .wzero_o       (wzero),
        .pe_load_o     (pe_load),
        .pe_clear_o    (pe_clear),
        .acc_valid_o   (acc_valid),
        .acc_last_o    (acc_last),
        .acc_final_o   (acc_final)
    );

    fc_pe_array u_pe_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (pe_load),
        .clear_i  (pe_clear),
        .ifmap_i  (ifmap_data),
        .weight_i (wbuf_data),
        .wzero_i  (wzero),
        .psum_o   (psum)
    );

    fc_accumulator u_acc (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_go),
        .psum_i         (psum),
        .valid_i        (acc_valid),
        .last_i         (acc_last),
        .final_i        (acc_final),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_last_o  (result_last_o)
    );

endmodule

`default_nettype wire

/* verification/fc_engine_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_engine_tb;

    localparam int N_RANDOM     = 10;
    localparam int NUM_LAYERS   = 2 * (6 + N_RANDOM);
    localparam int LAYER_CYC    = (fc_pkg::MAX_IN_NODES / fc_pkg::PE_NUM)
                                  * (2 * fc_pkg::PE_NUM + fc_pkg::MAX_OUT_NODES + 2) + 10;
    localparam int FILL_CYC     = 3 * (32 + 64) + 4;
    localparam int WATCHDOG_CYC = 4 * (NUM_LAYERS * LAYER_CYC + 2 * FILL_CYC + 40);

    logic                clk;
    logic                rst_n;
    logic                wr_valid_i;
    logic                wr_ready_o;
    logic                wr_sel_i;
    fc_pkg::wbuf_addr_t  wr_addr_i;
    fc_pkg::data_t       wr_ifmap_i;
    fc_pkg::wword_t      wr_weight_i;
    logic                start_i;
    logic [1:0]          layer_sel_i;
    fc_pkg::in_cnt_t     in_nodes_i;
    fc_pkg::out_cnt_t    out_nodes_i;
    logic                busy_o;
    logic                result_valid_o;
    fc_pkg::acc_t        result_data_o;
    logic                result_last_o;

    logic [15:0]         lfsr_q;
    fc_pkg::data_t       ifm_model [128];   // mirrors the ifmap buffer
    fc_pkg::wword_t      wt_model  [256];

    fc_engine_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_valid_i     (wr_valid_i),
        .wr_ready_o     (wr_ready_o),
        .wr_sel_i       (wr_sel_i),
        .wr_addr_i      (wr_addr_i),
        .wr_ifmap_i     (wr_ifmap_i),
        .wr_weight_i    (wr_weight_i),
        .start_i        (start_i),
        .layer_sel_i    (layer_sel_i),
        .in_nodes_i     (in_nodes_i),
        .out_nodes_i    (out_nodes_i),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_last_o  (result_last_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("timeout: the run hung, the DUT never finished its layers");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int ibuf_base(input logic [1:0] sel);
        case (sel)
            2'd1:    return int'(fc_pkg::IBUF_BASE1);
            2'd2:    return int'(fc_pkg::IBUF_BASE2);
            default: return int'(fc_pkg::IBUF_BASE0);   // 3 maps to slot 0
        endcase
    endfunction

    function automatic int wbuf_base(input logic [1:0] sel);
        case (sel)
            2'd1:    return int'(fc_pkg::WBUF_BASE1);
            2'd2:    return int'(fc_pkg::WBUF_BASE2);
            default: return int'(fc_pkg::WBUF_BASE0);
        endcase
    endfunction

    // relu of the dot product over all inputs for output j
    function automatic logic signed [63:0] expected_out(input logic [1:0] sel,
                                                        input int in_n, input int j);
        longint sum;
        int     tile;
        int     lane;
        int     waddr;
        sum = 0;
        for (int i = 0; i < in_n; i++) begin
            tile  = i / fc_pkg::PE_NUM;
            lane  = i % fc_pkg::PE_NUM;
            waddr = wbuf_base(sel) + tile * fc_pkg::MAX_OUT_NODES + j;
            sum += longint'(ifm_model[ibuf_base(sel) + i])
                 * longint'(fc_pkg::data_t'(wt_model[waddr][lane]));
        end
        return (sum < 0) ? 64'sd0 : 64'(sum);
    endfunction

    task automatic check(input string what, input logic signed [63:0] got,
                         input logic signed [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic write_word(input logic sel, input int addr, input fc_pkg::data_t d,
                              input fc_pkg::wword_t w);
        @(posedge clk);
        wr_valid_i  <= 1'b1;
        wr_sel_i    <= sel;
        wr_addr_i   <= fc_pkg::wbuf_addr_t'(addr);
        wr_ifmap_i  <= d;
        wr_weight_i <= w;
        @(negedge clk);
        check("wr_ready_o while idle", wr_ready_o, 1);
    endtask

    task automatic fill_slot(input logic [1:0] sel);
        fc_pkg::data_t  d;
        fc_pkg::wword_t w;
        for (int i = 0; i < fc_pkg::MAX_IN_NODES; i++) begin
            d = fc_pkg::data_t'(rand_bits(8));
            ifm_model[ibuf_base(sel) + i] = d;
            write_word(1'b0, ibuf_base(sel) + i, d, '0);
        end
        for (int a = 0; a < 4 * fc_pkg::MAX_OUT_NODES; a++) begin
            for (int lane = 0; lane < fc_pkg::PE_NUM; lane++) begin
                w[lane] = fc_pkg::data_t'(rand_bits(8));
            end
            wt_model[wbuf_base(sel) + a] = w;
            write_word(1'b1, wbuf_base(sel) + a, '0, w);
        end
    endtask

    task automatic run_layer(input logic [1:0] sel, input int in_n, input int out_n);
        int got_n;
        int cyc;
        bit done;
        @(posedge clk);
        start_i     <= 1'b1;
        layer_sel_i <= sel;
        in_nodes_i  <= fc_pkg::in_cnt_t'(in_n);
        out_nodes_i <= fc_pkg::out_cnt_t'(out_n);
        @(posedge clk);
        start_i <= 1'b0;
        got_n = 0;
        cyc   = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (result_valid_o) begin
                check("result_data_o", result_data_o, expected_out(sel, in_n, got_n));
                check("result_last_o", result_last_o, got_n == out_n - 1);
                got_n++;
                done = result_last_o;
            end else begin
                check("result_last_o without valid", result_last_o, 0);
            end
            if (!done) begin
                check("wr_ready_o while busy", wr_ready_o, 0);
            end
            @(posedge clk);
            cyc++;
            start_i <= (cyc == 2) || (got_n == 1 && out_n > 2);   // must be ignored while busy
            if (cyc == 2) begin
                layer_sel_i <= ~sel;
                in_nodes_i  <= fc_pkg::in_cnt_t'(3);
                out_nodes_i <= fc_pkg::out_cnt_t'(2);
            end
            if (cyc < 6) begin
                wr_valid_i  <= 1'b1;
                wr_sel_i    <= 1'(rand_bits(1));
                wr_addr_i   <= fc_pkg::wbuf_addr_t'(rand_bits(8));
                wr_ifmap_i  <= fc_pkg::data_t'(8'h7f);
                wr_weight_i <= '1;
            end else begin
                wr_valid_i <= 1'b0;
            end
        end
        repeat (3) begin
            @(negedge clk);
            check("result_valid_o after last", result_valid_o, 0);
            check("wr_ready_o after last", wr_ready_o, 1);
        end
    endtask

    initial begin
        logic [1:0] sel_r;
        int         in_r;
        int         out_r;
        lfsr_q      = 16'd35403;
        rst_n       = 1'b0;
        wr_valid_i  = 1'b0;
        wr_sel_i    = 1'b0;
        wr_addr_i   = '0;
        wr_ifmap_i  = '0;
        wr_weight_i = '0;
        start_i     = 1'b0;
        layer_sel_i = '0;
        in_nodes_i  = '0;
        out_nodes_i = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (16) begin   // idle after reset, no start
            @(negedge clk);
            check("result_valid_o after reset", result_valid_o, 0);
            check("result_last_o after reset", result_last_o, 0);
            check("wr_ready_o after reset", wr_ready_o, 1);
            check("busy_o after reset", busy_o, 0);
        end
        for (int round = 0; round < 2; round++) begin
            for (int s = 0; s < 3; s++) begin
                fill_slot(2'(s));
            end
            @(posedge clk);
            wr_valid_i <= 1'b0;
            run_layer(2'd0, 8, 16);
            run_layer(2'd1, 5, 3);
            run_layer(2'd2, 9, 7);
            run_layer(2'd0, 17, 10);
            run_layer(2'd1, 32, 16);
            run_layer(2'd3, 20, 12);
            for (int n = 0; n < N_RANDOM; n++) begin
                sel_r = 2'(rand_bits(2));
                in_r  = int'(rand_bits(5)) + 1;
                out_r = int'(rand_bits(4)) + 1;
                run_layer(sel_r, in_r, out_r);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* fc_engine.f */
hw/fc_pkg.sv
hw/fc_sram_buffer.sv
hw/fc_controller.sv
hw/fc_pe_array.sv
hw/fc_accumulator.sv
hw/fc_engine_top.sv
verification/fc_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fc_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fc_engine_sim
LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module fc_engine_tb \
        -f fc_engine.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
